// File: hdl/exc_pkg.sv
// exception unit package: widths, cause codes, target selectors, csr addresses, csr write union
package exc_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // cause code, top bit flags an interrupt
  localparam int cause_w   = 6;
  // handler target selector
  localparam int exc_sel_w = 3;
  // data and address width
  localparam int xlen      = 32;

  //////////////////////////////////////////////////
  // exception cause codes
  //////////////////////////////////////////////////

  localparam logic [cause_w-1:0] cause_illegal   = 6'd2;
  localparam logic [cause_w-1:0] cause_load_err  = 6'd5;
  localparam logic [cause_w-1:0] cause_store_err = 6'd7;
  localparam logic [cause_w-1:0] cause_ecall     = 6'd8;

  //////////////////////////////////////////////////
  // target selectors
  //////////////////////////////////////////////////

  localparam logic [exc_sel_w-1:0] sel_irq     = 3'd0;
  localparam logic [exc_sel_w-1:0] sel_illegal = 3'd1;
  localparam logic [exc_sel_w-1:0] sel_ecall   = 3'd2;
  localparam logic [exc_sel_w-1:0] sel_load    = 3'd3;
  localparam logic [exc_sel_w-1:0] sel_store   = 3'd4;

  // exception entries start here above mtvec, 4 bytes apart
  localparam logic [xlen-1:0] exc_base_off = 32'h80;

  //////////////////////////////////////////////////
  // csr addresses
  //////////////////////////////////////////////////

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  // csr write word, seen as mtvec or as mstatus
  typedef union packed {
    struct packed {
      logic [23:0] base;
      logic [7:0]  unused;
    } mtvec;
    struct packed {
      logic [23:0] unused_hi;
      logic        mpie;
      logic [2:0]  unused_mid;
      logic        mie;
      logic [2:0]  unused_lo;
    } mstatus;
  } csr_wdata_u;

endpackage

// File: hdl/exc_controller.sv
// exception controller: source priority, cause latch and request/ack FSM
module exc_controller (
  input  logic                          clk,
  input  logic                          rst_n,

  // level-triggered interrupt lines and global enable
  input  logic [31:0]                   irq_i,
  input  logic                          irq_enable_i,

  // decoder and lsu fault sources
  input  logic                          illegal_insn_i,
  input  logic                          ecall_insn_i,
  input  logic                          eret_insn_i,
  input  logic                          lsu_load_err_i,
  input  logic                          lsu_store_err_i,

  // handshake with redirect control
  input  logic                          ack_i,
  output logic                          req_o,

  // trap events towards csr block
  output logic                          save_cause_o,
  output logic                          eret_o,
  output logic [exc_pkg::cause_w-1:0]   cause_o,
  output logic [exc_pkg::exc_sel_w-1:0] sel_o,
  output logic [4:0]                    vec_o
);

  import exc_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT_ACK, IN_ISR} exc_state_t;

  exc_state_t             state_q, state_d;
  logic                   req_int;
  logic [cause_w-1:0]     cause_int, cause_q;
  logic [exc_sel_w-1:0]   sel_int, sel_q;
  logic                   bypass;

  // any source present
  assign req_int = illegal_insn_i | ecall_insn_i | lsu_load_err_i | lsu_store_err_i |
                   (irq_enable_i & (|irq_i));

  //////////////////////////////////////////////////
  // priority, later assignments win
  //////////////////////////////////////////////////

  always_comb begin
    cause_int = '0;
    sel_int   = sel_irq;
    // downward scan leaves the lowest enabled line
    for (int i = 31; i >= 0; i--) begin
      if (irq_enable_i && irq_i[i]) begin
        cause_int = {1'b1, 5'(i)};
        sel_int   = sel_irq;
      end
    end
    if (ecall_insn_i) begin
      cause_int = cause_ecall;
      sel_int   = sel_ecall;
    end
    if (illegal_insn_i) begin
      cause_int = cause_illegal;
      sel_int   = sel_illegal;
    end
    if (lsu_load_err_i) begin
      cause_int = cause_load_err;
      sel_int   = sel_load;
    end
    // store error is top priority
    if (lsu_store_err_i) begin
      cause_int = cause_store_err;
      sel_int   = sel_store;
    end
  end

  // latch on first sight of a request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cause_q <= '0;
      sel_q   <= sel_irq;
    end else if (bypass) begin
      cause_q <= cause_int;
      sel_q   <= sel_int;
    end
  end

  // pass through while idle, held value while waiting
  assign bypass  = (state_q == IDLE) && req_int;
  assign cause_o = bypass ? cause_int : cause_q;
  assign sel_o   = bypass ? sel_int : sel_q;
  // vector index only for interrupts
  assign vec_o   = cause_o[cause_w-1] ? cause_o[4:0] : 5'd0;

  //////////////////////////////////////////////////
  // request fsm
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    req_o        = 1'b0;
    save_cause_o = 1'b0;
    eret_o       = 1'b0;
    case (state_q)
      IDLE: begin
        req_o = req_int;
        if (req_int) begin
          state_d = WAIT_ACK;
          // same-cycle ack goes straight to handler
          if (ack_i) begin
            save_cause_o = 1'b1;
            state_d      = IN_ISR;
          end
        end
      end
      WAIT_ACK: begin
        req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = IN_ISR;
        end
      end
      IN_ISR: begin
        // new sources ignored until return
        if (eret_insn_i) begin
          eret_o  = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hdl/exc_csr.sv
// machine trap csrs: mtvec, mstatus, mcause, mepc with software port and trap save/restore
module exc_csr (
  input  logic                        clk,
  input  logic                        rst_n,

  // software access
  input  logic [11:0]                 csr_addr_i,
  input  logic                        csr_we_i,
  input  exc_pkg::csr_wdata_u         csr_wdata_i,
  output logic [exc_pkg::xlen-1:0]    csr_rdata_o,

  // trap entry and return
  input  logic                        save_cause_i,
  input  logic                        eret_i,
  input  logic [exc_pkg::cause_w-1:0] cause_i,
  input  logic [exc_pkg::xlen-1:0]    epc_i,

  // state for controller and target unit
  output logic                        irq_enable_o,
  output logic [exc_pkg::xlen-1:0]    mtvec_o,
  output logic [exc_pkg::xlen-1:0]    mepc_o
);

  import exc_pkg::*;

  logic [23:0]        mtvec_base_q;
  logic               mie_q;
  logic               mpie_q;
  logic [cause_w-1:0] mcause_q;
  logic [xlen-1:0]    mepc_q;

  //////////////////////////////////////////////////
  // register updates
  //////////////////////////////////////////////////

  // handler base, 256-byte aligned
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec_base_q <= '0;
    end else if (csr_we_i && csr_addr_i == csr_mtvec) begin
      mtvec_base_q <= csr_wdata_i.mtvec.base;
    end
  end

  // mstatus, trap events win over software
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
    end else if (save_cause_i) begin
      mpie_q <= mie_q;
      mie_q  <= 1'b0;
    end else if (eret_i) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
    end else if (csr_we_i && csr_addr_i == csr_mstatus) begin
      mie_q  <= csr_wdata_i.mstatus.mie;
      mpie_q <= csr_wdata_i.mstatus.mpie;
    end
  end

  // cause and return pc captured on entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcause_q <= '0;
      mepc_q   <= '0;
    end else if (save_cause_i) begin
      mcause_q <= cause_i;
      mepc_q   <= epc_i;
    end else if (csr_we_i) begin
      if (csr_addr_i == csr_mcause) begin
        // interrupt flag lives in bit 31 of the word
        mcause_q <= {csr_wdata_i[31], csr_wdata_i[4:0]};
      end
      if (csr_addr_i == csr_mepc) begin
        mepc_q <= csr_wdata_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // read mux, unknown addresses read 0
  //////////////////////////////////////////////////

  always_comb begin
    case (csr_addr_i)
      csr_mstatus: csr_rdata_o = {24'd0, mpie_q, 3'd0, mie_q, 3'd0};
      csr_mtvec:   csr_rdata_o = mtvec_o;
      csr_mepc:    csr_rdata_o = mepc_q;
      csr_mcause:  csr_rdata_o = {mcause_q[cause_w-1], 26'd0, mcause_q[4:0]};
      default:     csr_rdata_o = '0;
    endcase
  end

  assign irq_enable_o = mie_q;
  assign mtvec_o      = {mtvec_base_q, 8'h00};
  assign mepc_o       = mepc_q;

endmodule

// File: hdl/trap_target.sv
// trap target unit: registered handler or return address
module trap_target (
  input  logic                          clk,
  input  logic                          rst_n,

  // trap accepted or return taken
  input  logic                          load_i,
  input  logic                          eret_i,

  // handler selection from controller
  input  logic [exc_pkg::exc_sel_w-1:0] sel_i,
  input  logic [4:0]                    vec_i,

  // csr values
  input  logic [exc_pkg::xlen-1:0]      mtvec_i,
  input  logic [exc_pkg::xlen-1:0]      mepc_i,

  output logic [exc_pkg::xlen-1:0]      pc_target_o
);

  import exc_pkg::*;

  logic [xlen-1:0] irq_addr;
  logic [xlen-1:0] exc_addr;
  logic [xlen-1:0] target_d;
  logic [xlen-1:0] target_q;

  //////////////////////////////////////////////////
  // address generation
  //////////////////////////////////////////////////

  // interrupt entries straight above base
  assign irq_addr = mtvec_i + xlen'({vec_i, 2'b00});
  // exception entries start at the fixed offset
  assign exc_addr = mtvec_i + exc_base_off + xlen'({sel_i, 2'b00});

  always_comb begin
    if (eret_i) begin
      target_d = mepc_i;
    end else if (sel_i == sel_irq) begin
      target_d = irq_addr;
    end else begin
      target_d = exc_addr;
    end
  end

  // hold between events, lines up with pc_set strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      target_q <= '0;
    end else if (load_i || eret_i) begin
      target_q <= target_d;
    end
  end

  assign pc_target_o = target_q;

endmodule

// File: hdl/pipe_redirect.sv
// pipeline redirect control: trap acknowledge on drained pipe, one-cycle pc set strobe
module pipe_redirect (
  input  logic clk,
  input  logic rst_n,

  // request from exception controller
  input  logic req_i,
  // no instructions left in flight
  input  logic pipe_empty_i,

  // trap events from controller
  input  logic save_cause_i,
  input  logic eret_i,

  output logic ack_o,
  output logic pc_set_o
);

  logic redirect_d;
  logic pc_set_q;

  //////////////////////////////////////////////////
  // acknowledge
  //////////////////////////////////////////////////

  // accept only once the pipeline has drained
  // a low pipe_empty_i just stretches the request
  assign ack_o = req_i & pipe_empty_i;

  //////////////////////////////////////////////////
  // redirect strobe
  //////////////////////////////////////////////////

  // trap entry or return both need a jump
  assign redirect_d = save_cause_i | eret_i;

  // one register delay so the strobe meets the
  // registered target address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_set_q <= 1'b0;
    end else begin
      pc_set_q <= redirect_d;
    end
  end

  // one cycle per trap entry or return
  assign pc_set_o = pc_set_q;

endmodule

// File: hdl/exc_unit_top.sv
// exception unit top level: controller, csr block, redirect control and target unit
module exc_unit_top (
  input  logic                     clk,
  input  logic                     rst_n,

  // interrupt lines
  input  logic [31:0]              irq_i,

  // decoder and lsu sources
  input  logic                     illegal_insn_i,
  input  logic                     ecall_insn_i,
  input  logic                     eret_insn_i,
  input  logic                     lsu_load_err_i,
  input  logic                     lsu_store_err_i,

  // software csr port
  input  logic [11:0]              csr_addr_i,
  input  logic                     csr_we_i,
  input  exc_pkg::csr_wdata_u      csr_wdata_i,
  output logic [exc_pkg::xlen-1:0] csr_rdata_o,

  // pipeline side
  input  logic [exc_pkg::xlen-1:0] epc_i,
  input  logic                     pipe_empty_i,
  output logic                     pc_set_o,
  output logic [exc_pkg::xlen-1:0] pc_target_o
);

  import exc_pkg::*;

  // handshake and event strobes
  logic                 exc_req;
  logic                 exc_ack;
  logic                 save_cause;
  logic                 eret;
  // trap description
  logic [cause_w-1:0]   cause;
  logic [exc_sel_w-1:0] sel;
  logic [4:0]           vec;
  // csr state
  logic                 irq_enable;
  logic [xlen-1:0]      mtvec;
  logic [xlen-1:0]      mepc;

  exc_controller exc_controller_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .irq_i           (irq_i),
    .irq_enable_i    (irq_enable),
    .illegal_insn_i  (illegal_insn_i),
    .ecall_insn_i    (ecall_insn_i),
    .eret_insn_i     (eret_insn_i),
    .lsu_load_err_i  (lsu_load_err_i),
    .lsu_store_err_i (lsu_store_err_i),
    .ack_i           (exc_ack),
    .req_o           (exc_req),
    .save_cause_o    (save_cause),
    .eret_o          (eret),
    .cause_o         (cause),
    .sel_o           (sel),
    .vec_o           (vec)
  );

  exc_csr exc_csr_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_addr_i   (csr_addr_i),
    .csr_we_i     (csr_we_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .save_cause_i (save_cause),
    .eret_i       (eret),
    .cause_i      (cause),
    .epc_i        (epc_i),
    .irq_enable_o (irq_enable),
    .mtvec_o      (mtvec),
    .mepc_o       (mepc)
  );

  pipe_redirect pipe_redirect_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (exc_req),
    .pipe_empty_i (pipe_empty_i),
    .save_cause_i (save_cause),
    .eret_i       (eret),
    .ack_o        (exc_ack),
    .pc_set_o     (pc_set_o)
  );

  trap_target trap_target_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_i      (save_cause),
    .eret_i      (eret),
    .sel_i       (sel),
    .vec_i       (vec),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc),
    .pc_target_o (pc_target_o)
  );

endmodule

// File: verification/exc_unit_tb.sv
// exception unit testbench: clock, reset, dut instance, directed trap tests, compare tasks, watchdog
module exc_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import exc_pkg::*;

  localparam int clk_period   = 4;
  localparam int reset_cycles = 16;
  // rough cycle budget of each test, in run order
  localparam int test_cycles  = 40 + 50 + 60 + 30 + 40 + 50;

  logic              clk;
  logic              rst_n;
  logic [31:0]       irq_i;
  logic              illegal_insn_i;
  logic              ecall_insn_i;
  logic              eret_insn_i;
  logic              lsu_load_err_i;
  logic              lsu_store_err_i;
  logic [11:0]       csr_addr_i;
  logic              csr_we_i;
  csr_wdata_u        csr_wdata_i;
  logic [xlen-1:0]   csr_rdata_o;
  logic [xlen-1:0]   epc_i;
  logic              pipe_empty_i;
  logic              pc_set_o;
  logic [xlen-1:0]   pc_target_o;

  integer seed = 32'h75d234ae;
  int     error_count = 0;

  exc_unit_top exc_unit_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .irq_i           (irq_i),
    .illegal_insn_i  (illegal_insn_i),
    .ecall_insn_i    (ecall_insn_i),
    .eret_insn_i     (eret_insn_i),
    .lsu_load_err_i  (lsu_load_err_i),
    .lsu_store_err_i (lsu_store_err_i),
    .csr_addr_i      (csr_addr_i),
    .csr_we_i        (csr_we_i),
    .csr_wdata_i     (csr_wdata_i),
    .csr_rdata_o     (csr_rdata_o),
    .epc_i           (epc_i),
    .pipe_empty_i    (pipe_empty_i),
    .pc_set_o        (pc_set_o),
    .pc_target_o     (pc_target_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // error and compare tasks
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_cause(input string name, input logic [cause_w-1:0] got,
                             input logic [cause_w-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // bus and strobe helpers
  //////////////////////////////////////////////////

  // one-cycle software write
  task automatic csr_write(input logic [11:0] addr, input logic [xlen-1:0] data);
    @(posedge clk);
    csr_addr_i  <= addr;
    csr_we_i    <= 1'b1;
    csr_wdata_i <= data;
    @(posedge clk);
    csr_we_i    <= 1'b0;
  endtask

  // read is combinational, sampled mid-cycle
  task automatic csr_read(input logic [11:0] addr, output logic [xlen-1:0] data);
    @(posedge clk);
    csr_addr_i <= addr;
    @(negedge clk);
    data = csr_rdata_o;
  endtask

  // strobe must show up by the given negedge
  task automatic wait_pc_set(input int max_cycles, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!pc_set_o) begin
      n++;
      if (n >= max_cycles) begin
        report_error($sformatf("no pc_set_o within %0d cycles after %s", max_cycles, what));
      end
      @(negedge clk);
    end
  endtask

  task automatic expect_no_pc_set(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk);
      if (pc_set_o) begin
        report_error($sformatf("pc_set_o rose at %0t ns %s", $time, what));
      end
    end
  endtask

  // one-cycle eret, redirect back to mepc
  task automatic take_eret(input logic [xlen-1:0] exp_target);
    @(posedge clk);
    eret_insn_i <= 1'b1;
    @(posedge clk);
    eret_insn_i <= 1'b0;
    wait_pc_set(1, "eret");
    check_addr("pc_target_o", pc_target_o, exp_target);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic masked_irq_ignored();
    logic [xlen-1:0] word;
    @(posedge clk);
    irq_i <= 32'h0000_0010;
    expect_no_pc_set(20, "with interrupts masked");
    csr_read(csr_mstatus, word);
    check_addr("mstatus", word, 32'h0);
    @(posedge clk);
    irq_i <= '0;
  endtask

  task automatic lowest_irq_wins();
    int              lo;
    int              hi;
    logic [xlen-1:0] word;
    // lo in 0..30, hi strictly above it
    lo = {$random(seed)} % 31;
    hi = lo + 1 + ({$random(seed)} % (31 - lo));
    // low byte of mtvec is dropped
    csr_write(csr_mtvec, 32'h0000_12ab);
    csr_read(csr_mtvec, word);
    check_addr("mtvec", word, 32'h0000_1200);
    csr_write(csr_mstatus, 32'h0000_0008);
    @(posedge clk);
    epc_i <= 32'h2000_0040;
    irq_i <= (32'h1 << lo) | (32'h1 << hi);
    wait_pc_set(2, "interrupt");
    check_addr("pc_target_o", pc_target_o, 32'h0000_1200 + 32'(4 * lo));
    @(posedge clk);
    irq_i <= '0;
    csr_read(csr_mcause, word);
    check_cause("mcause", {word[31], word[4:0]}, {1'b1, 5'(lo)});
    csr_read(csr_mepc, word);
    check_addr("mepc", word, 32'h2000_0040);
    // mpie keeps the old mie, mie cleared
    csr_read(csr_mstatus, word);
    check_addr("mstatus", word, 32'h0000_0080);
    take_eret(32'h2000_0040);
  endtask

  task automatic fault_priority();
    logic [xlen-1:0] word;
    @(posedge clk);
    epc_i          <= 32'h2000_0100;
    illegal_insn_i <= 1'b1;
    ecall_insn_i   <= 1'b1;
    lsu_load_err_i <= 1'b1;
    wait_pc_set(2, "illegal, ecall and load error");
    // exception base 0x80, load entry 3
    check_addr("pc_target_o", pc_target_o, 32'h0000_128c);
    @(posedge clk);
    illegal_insn_i <= 1'b0;
    ecall_insn_i   <= 1'b0;
    lsu_load_err_i <= 1'b0;
    csr_read(csr_mcause, word);
    check_cause("mcause", {word[31], word[4:0]}, cause_load_err);
    take_eret(32'h2000_0100);
    // store beats load
    @(posedge clk);
    epc_i           <= 32'h2000_0104;
    lsu_load_err_i  <= 1'b1;
    lsu_store_err_i <= 1'b1;
    wait_pc_set(2, "store and load error");
    check_addr("pc_target_o", pc_target_o, 32'h0000_1290);
    @(posedge clk);
    lsu_load_err_i  <= 1'b0;
    lsu_store_err_i <= 1'b0;
    csr_read(csr_mcause, word);
    check_cause("mcause", {word[31], word[4:0]}, cause_store_err);
    take_eret(32'h2000_0104);
  endtask

  task automatic stalled_ack();
    @(posedge clk);
    epc_i        <= 32'h2000_0200;
    pipe_empty_i <= 1'b0;
    ecall_insn_i <= 1'b1;
    expect_no_pc_set(5, "while the pipeline is busy");
    // accepted cycle starts here, strobe one cycle later
    @(posedge clk);
    pipe_empty_i <= 1'b1;
    expect_no_pc_set(1, "in the accepted cycle");
    wait_pc_set(1, "pipeline drained");
    check_addr("pc_target_o", pc_target_o, 32'h0000_1288);
    @(posedge clk);
    ecall_insn_i <= 1'b0;
    take_eret(32'h2000_0200);
  endtask

  task automatic eret_return();
    logic [xlen-1:0] word;
    @(posedge clk);
    epc_i          <= 32'h2000_0300;
    illegal_insn_i <= 1'b1;
    wait_pc_set(2, "illegal instruction");
    check_addr("pc_target_o", pc_target_o, 32'h0000_1284);
    @(posedge clk);
    illegal_insn_i <= 1'b0;
    take_eret(32'h2000_0300);
    // mie back from mpie, mpie set
    csr_read(csr_mstatus, word);
    check_addr("mstatus", word, 32'h0000_0088);
    // no handler active now
    @(posedge clk);
    eret_insn_i <= 1'b1;
    @(posedge clk);
    eret_insn_i <= 1'b0;
    expect_no_pc_set(5, "for an eret outside the handler");
    check_addr("pc_target_o", pc_target_o, 32'h2000_0300);
  endtask

  task automatic fault_during_isr();
    logic [xlen-1:0] word;
    @(posedge clk);
    epc_i        <= 32'h2000_0400;
    ecall_insn_i <= 1'b1;
    wait_pc_set(2, "ecall");
    check_addr("pc_target_o", pc_target_o, 32'h0000_1288);
    @(posedge clk);
    ecall_insn_i   <= 1'b0;
    lsu_load_err_i <= 1'b1;
    epc_i          <= 32'h2000_0500;
    expect_no_pc_set(10, "for a fault inside the handler");
    csr_read(csr_mcause, word);
    check_cause("mcause", {word[31], word[4:0]}, cause_ecall);
    take_eret(32'h2000_0400);
    // held load error is taken right after the return
    wait_pc_set(1, "load error held across eret");
    check_addr("pc_target_o", pc_target_o, 32'h0000_128c);
    @(posedge clk);
    lsu_load_err_i <= 1'b0;
    csr_read(csr_mcause, word);
    check_cause("mcause", {word[31], word[4:0]}, cause_load_err);
    csr_read(csr_mepc, word);
    check_addr("mepc", word, 32'h2000_0500);
    take_eret(32'h2000_0500);
  endtask

  //////////////////////////////////////////////////
  // sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    rst_n           = 1'b0;
    irq_i           = '0;
    illegal_insn_i  = 1'b0;
    ecall_insn_i    = 1'b0;
    eret_insn_i     = 1'b0;
    lsu_load_err_i  = 1'b0;
    lsu_store_err_i = 1'b0;
    csr_addr_i      = '0;
    csr_we_i        = 1'b0;
    csr_wdata_i     = '0;
    epc_i           = '0;
    pipe_empty_i    = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    masked_irq_ignored();
    lowest_irq_wins();
    fault_priority();
    stalled_ack();
    eret_return();
    fault_during_isr();
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // twice the summed budget
  initial begin
    #((reset_cycles + test_cycles) * clk_period * 2);
    report_error("watchdog expired before the tests finished");
  end

endmodule

// File: vlog.f
hdl/exc_pkg.sv
hdl/exc_controller.sv
hdl/exc_csr.sv
hdl/trap_target.sv
hdl/pipe_redirect.sv
hdl/exc_unit_top.sv
verification/exc_unit_tb.sv

// File: Makefile
# Verilator build and run for the exception unit testbench

TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := exc_unit_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
PASS_MSG := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
